//--- cfo_frontend.f
source/rx_pkg.sv
source/cfo_tracker.sv
source/nco_lut.sv
source/complex_rotator.sv
source/cfo_frontend.sv
testbench/tb_cfo_frontend.sv

//--- run_sim.sh
#!/bin/sh
# builds and runs the CFO front end testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal \
    -f cfo_frontend.f \
    --top-module tb_cfo_frontend \
    -o tb_cfo_frontend; then
    echo "verilator compile failed"
    exit 1
fi

if ! ./obj_dir/tb_cfo_frontend; then
    echo "simulation reported failure"
    exit 1
fi

echo "simulation finished"
exit 0

//--- testbench/tb_cfo_frontend.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cfo_frontend;

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 16;
    localparam int DRAIN_LIMIT  = 40;
    localparam int COMP_MAX     = 16383;

    logic                               clk_i;
    logic                               reset_ni;
    logic [rx_pkg::SAMPLE_DW-1:0]       sample_i;
    logic                               sample_valid_i;
    logic signed [rx_pkg::PHASE_DW-1:0] cfo_inc_i;
    logic                               cfo_valid_i;
    rx_pkg::cfo_mode_e                  cfo_mode_i;
    logic [rx_pkg::SAMPLE_DW-1:0]       sample_o;
    logic [rx_pkg::SAMPLE_ID_DW-1:0]    sample_id_o;
    logic                               sample_valid_o;

    // tracker model state
    logic signed [rx_pkg::PHASE_DW-1:0] model_inc;
    logic [rx_pkg::PHASE_DW-1:0]        model_phase;
    logic [rx_pkg::SAMPLE_ID_DW-1:0]    model_id;

    logic [rx_pkg::SAMPLE_DW-1:0]       exp_sample_q [$];
    logic [rx_pkg::SAMPLE_ID_DW-1:0]    exp_id_q [$];
    logic [rx_pkg::SAMPLE_DW-1:0]       exp_sample;
    logic [rx_pkg::SAMPLE_ID_DW-1:0]    exp_id;

    cfo_frontend #(
        .IQ_W (rx_pkg::IQ_DW)
    ) UUT (
        .clk_i          (clk_i),
        .reset_ni       (reset_ni),
        .sample_i       (sample_i),
        .sample_valid_i (sample_valid_i),
        .cfo_inc_i      (cfo_inc_i),
        .cfo_valid_i    (cfo_valid_i),
        .cfo_mode_i     (cfo_mode_i),
        .sample_o       (sample_o),
        .sample_id_o    (sample_id_o),
        .sample_valid_o (sample_valid_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    task automatic stop_run(input string reason);
        $display("%s", reason);
        $display("TEST FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] expected);
        stop_run($sformatf("error: %s got 0x%h expected 0x%h", name, got, expected));
    endtask

    // expected output is the sample rotated by the phase sector
    function automatic logic [rx_pkg::SAMPLE_DW-1:0] rotate_sample(
        input logic [rx_pkg::SAMPLE_DW-1:0] smp,
        input logic [rx_pkg::PHASE_DW-1:0]  phase
    );
        int     k;
        longint in_i;
        longint in_q;
        longint c;
        longint s;
        longint out_i;
        longint out_q;
        k     = int'(phase[rx_pkg::PHASE_DW-1 -: rx_pkg::LUT_BITS]);
        in_i  = longint'($signed(smp[rx_pkg::IQ_DW-1:0]));
        in_q  = longint'($signed(smp[rx_pkg::SAMPLE_DW-1:rx_pkg::IQ_DW]));
        c     = longint'(rx_pkg::COS_TABLE[k]);
        s     = longint'(rx_pkg::SIN_TABLE[k]);
        out_i = (in_i * c - in_q * s) >>> rx_pkg::FRAC_BITS;
        out_q = (in_i * s + in_q * c) >>> rx_pkg::FRAC_BITS;
        return {out_q[rx_pkg::IQ_DW-1:0], out_i[rx_pkg::IQ_DW-1:0]};
    endfunction

    function automatic logic [rx_pkg::SAMPLE_DW-1:0] random_sample();
        int comp_i;
        int comp_q;
        comp_i = int'($urandom_range(2 * COMP_MAX, 0)) - COMP_MAX;
        comp_q = int'($urandom_range(2 * COMP_MAX, 0)) - COMP_MAX;
        return {16'(comp_q), 16'(comp_i)};
    endfunction

    // pops the expectation for an output seen in this cycle
    task automatic collect_output();
        if (sample_valid_o) begin
            if (exp_sample_q.size() == 0) begin
                stop_run("an output sample appeared with no input sample pending");
            end else begin
                exp_sample = exp_sample_q.pop_front();
                exp_id     = exp_id_q.pop_front();
            end
        end
    endtask

    // ------------------------------------------------------------------------
    // one falling edge of stimulus plus the model step for the next edge
    // ------------------------------------------------------------------------
    task automatic drive_cycle(input logic valid, input logic [rx_pkg::SAMPLE_DW-1:0] smp,
                               input logic report, input logic [rx_pkg::PHASE_DW-1:0] inc,
                               input rx_pkg::cfo_mode_e mode);
        @(negedge clk_i);
        collect_output();
        sample_valid_i = valid;
        sample_i       = smp;
        cfo_valid_i    = report;
        cfo_inc_i      = inc;
        cfo_mode_i     = mode;
        if (valid) begin
            exp_sample_q.push_back(rotate_sample(smp, model_phase));
            exp_id_q.push_back(model_id);
            model_id = model_id + 1;
        end
        if (mode == rx_pkg::CFO_MANUAL) begin
            model_inc   = '0;
            model_phase = '0;
        end else begin
            // step with the increment held before this edge
            if (valid) begin
                model_phase = model_phase + $unsigned(model_inc);
            end
            if (report) begin
                model_inc = model_inc - $signed(inc);
            end
        end
    endtask

    task automatic random_cycle(input rx_pkg::cfo_mode_e mode, input int sample_pct,
                                input int report_pct);
        logic valid;
        logic report;
        valid  = ($urandom_range(99, 0) < sample_pct);
        report = ($urandom_range(99, 0) < report_pct);
        drive_cycle(valid, random_sample(), report, 20'($urandom()), mode);
    endtask

    // ------------------------------------------------------------------------
    // checks
    // ------------------------------------------------------------------------
    latency_check: assert property (
        @(posedge clk_i) disable iff (!reset_ni)
        sample_valid_o == $past(sample_valid_i, 4)
    ) else stop_run("sample_valid_o did not follow sample_valid_i by exactly 4 cycles");

    sample_check: assert property (
        @(posedge clk_i) disable iff (!reset_ni)
        sample_valid_o |-> (sample_o == exp_sample)
    ) else report_mismatch("sample_o", 64'($sampled(sample_o)), 64'($sampled(exp_sample)));

    id_check: assert property (
        @(posedge clk_i) disable iff (!reset_ni)
        sample_valid_o |-> (sample_id_o == exp_id)
    ) else report_mismatch("sample_id_o", $sampled(sample_id_o), $sampled(exp_id));

    initial begin
        int unsigned waited;
        void'($urandom(32'h3e4a7ad9));
        reset_ni       = 1'b0;
        sample_i       = '0;
        sample_valid_i = 1'b0;
        cfo_inc_i      = '0;
        cfo_valid_i    = 1'b0;
        cfo_mode_i     = rx_pkg::CFO_AUTO;
        model_inc      = '0;
        model_phase    = '0;
        model_id       = '0;
        exp_sample     = '0;
        exp_id         = '0;
        repeat (RESET_CYCLES) @(negedge clk_i);
        reset_ni = 1'b1;

        // idle cycles and zero increment samples back to back and with gaps
        repeat (6) drive_cycle(1'b0, '0, 1'b0, '0, rx_pkg::CFO_AUTO);
        repeat (12) drive_cycle(1'b1, random_sample(), 1'b0, '0, rx_pkg::CFO_AUTO);
        repeat (30) random_cycle(rx_pkg::CFO_AUTO, 60, 0);

        // relative reports with random gaps
        repeat (300) random_cycle(rx_pkg::CFO_AUTO, 75, 20);

        // manual mode clears the phase before accumulation restarts
        repeat (40) random_cycle(rx_pkg::CFO_MANUAL, 70, 30);
        repeat (200) random_cycle(rx_pkg::CFO_AUTO, 75, 20);

        waited = 0;
        while (exp_sample_q.size() != 0) begin
            if (waited == DRAIN_LIMIT) begin
                stop_run("timeout while waiting for the pipeline to drain");
            end else begin
                drive_cycle(1'b0, '0, 1'b0, '0, rx_pkg::CFO_AUTO);
                waited++;
            end
        end
        // let the last output and the latency check settle
        repeat (6) drive_cycle(1'b0, '0, 1'b0, '0, rx_pkg::CFO_AUTO);

        $display("TEST PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- source/cfo_frontend.sv
`timescale 1ns/1ps
`default_nettype none

module cfo_frontend #(
    parameter int IQ_W = rx_pkg::IQ_DW
) (
    input  wire                                      clk_i,
    input  wire                                      reset_ni,
    input  wire        [rx_pkg::SAMPLE_DW-1:0]       sample_i,
    input  wire                                      sample_valid_i,
    input  wire signed [rx_pkg::PHASE_DW-1:0]        cfo_inc_i,
    input  wire                                      cfo_valid_i,
    input  wire rx_pkg::cfo_mode_e                   cfo_mode_i,
    output logic       [rx_pkg::SAMPLE_DW-1:0]       sample_o,
    output logic       [rx_pkg::SAMPLE_ID_DW-1:0]    sample_id_o,
    output logic                                     sample_valid_o
);

    // tracker to lookup
    logic [rx_pkg::SAMPLE_DW-1:0]    track_sample;
    logic [rx_pkg::PHASE_DW-1:0]     track_phase;
    logic [rx_pkg::SAMPLE_ID_DW-1:0] track_id;
    logic                            track_valid;

    // lookup to rotator
    logic [rx_pkg::SAMPLE_DW-1:0]    lut_sample;
    logic signed [IQ_W-1:0]          lut_cos;
    logic signed [IQ_W-1:0]          lut_sin;
    logic [rx_pkg::SAMPLE_ID_DW-1:0] lut_id;
    logic                            lut_valid;

    cfo_tracker cfo_tracker_i (
        .clk_i          (clk_i),
        .reset_ni       (reset_ni),
        .sample_i       (sample_i),
        .sample_valid_i (sample_valid_i),
        .cfo_inc_i      (cfo_inc_i),
        .cfo_valid_i    (cfo_valid_i),
        .cfo_mode_i     (cfo_mode_i),
        .sample_o       (track_sample),
        .phase_o        (track_phase),
        .sample_id_o    (track_id),
        .sample_valid_o (track_valid)
    );

    nco_lut #(
        .IQ_W (IQ_W)
    ) nco_lut_i (
        .clk_i       (clk_i),
        .reset_ni    (reset_ni),
        .sample_i    (track_sample),
        .phase_i     (track_phase),
        .sample_id_i (track_id),
        .valid_i     (track_valid),
        .sample_o    (lut_sample),
        .cos_o       (lut_cos),
        .sin_o       (lut_sin),
        .sample_id_o (lut_id),
        .valid_o     (lut_valid)
    );

    complex_rotator #(
        .IQ_W (IQ_W)
    ) complex_rotator_i (
        .clk_i       (clk_i),
        .reset_ni    (reset_ni),
        .sample_i    (lut_sample),
        .cos_i       (lut_cos),
        .sin_i       (lut_sin),
        .sample_id_i (lut_id),
        .valid_i     (lut_valid),
        .sample_o    (sample_o),
        .sample_id_o (sample_id_o),
        .valid_o     (sample_valid_o)
    );

endmodule

`default_nettype wire

//--- source/complex_rotator.sv
`timescale 1ns/1ps
`default_nettype none

module complex_rotator #(
    parameter int IQ_W = 16
) (
    input  wire                                   clk_i,
    input  wire                                   reset_ni,
    input  wire  [rx_pkg::SAMPLE_DW-1:0]          sample_i,
    input  wire  signed [IQ_W-1:0]                cos_i,
    input  wire  signed [IQ_W-1:0]                sin_i,
    input  wire  [rx_pkg::SAMPLE_ID_DW-1:0]       sample_id_i,
    input  wire                                   valid_i,
    output logic [rx_pkg::SAMPLE_DW-1:0]          sample_o,
    output logic [rx_pkg::SAMPLE_ID_DW-1:0]       sample_id_o,
    output logic                                  valid_o
);

    localparam int HALF   = rx_pkg::SAMPLE_DW / 2;
    localparam int PROD_W = HALF + IQ_W;
    localparam int SUM_W  = PROD_W + 1;

    logic signed [HALF-1:0]   in_i;
    logic signed [HALF-1:0]   in_q;
    logic signed [PROD_W-1:0] p_ic;
    logic signed [PROD_W-1:0] p_qs;
    logic signed [PROD_W-1:0] p_is;
    logic signed [PROD_W-1:0] p_qc;
    logic [rx_pkg::SAMPLE_ID_DW-1:0] id_d1;
    logic                     valid_d1;
    logic signed [SUM_W-1:0]  sum_i;
    logic signed [SUM_W-1:0]  sum_q;
    logic signed [IQ_W-1:0]   rot_i;
    logic signed [IQ_W-1:0]   rot_q;

    // I in the low half, Q in the high half
    assign in_i = sample_i[HALF-1:0];
    assign in_q = sample_i[rx_pkg::SAMPLE_DW-1:HALF];

    // ------------------------------------------------------------------------
    // stage 1, products
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            p_ic  <= in_i * cos_i;
            p_qs  <= in_q * sin_i;
            p_is  <= in_i * sin_i;
            p_qc  <= in_q * cos_i;
            id_d1 <= sample_id_i;
        end
    end

    // ------------------------------------------------------------------------
    // stage 2, sums scaled back to sample width
    // ------------------------------------------------------------------------
    always_comb begin
        sum_i = SUM_W'(p_ic) - SUM_W'(p_qs);
        sum_q = SUM_W'(p_is) + SUM_W'(p_qc);
        rot_i = IQ_W'(sum_i >>> rx_pkg::FRAC_BITS);
        rot_q = IQ_W'(sum_q >>> rx_pkg::FRAC_BITS);
    end

    always_ff @(posedge clk_i) begin
        if (valid_d1) begin
            sample_o    <= {HALF'(rot_q), HALF'(rot_i)};
            sample_id_o <= id_d1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            valid_d1 <= 1'b0;
            valid_o  <= 1'b0;
        end else begin
            valid_d1 <= valid_i;
            valid_o  <= valid_d1;
        end
    end

    valid_known: assert property (
        @(posedge clk_i) disable iff (!reset_ni) !$isunknown(valid_o)
    );

endmodule

`default_nettype wire

//--- source/nco_lut.sv
`timescale 1ns/1ps
`default_nettype none

module nco_lut #(
    parameter int IQ_W = 16
) (
    input  wire                                   clk_i,
    input  wire                                   reset_ni,
    input  wire  [rx_pkg::SAMPLE_DW-1:0]          sample_i,
    input  wire  [rx_pkg::PHASE_DW-1:0]           phase_i,
    input  wire  [rx_pkg::SAMPLE_ID_DW-1:0]       sample_id_i,
    input  wire                                   valid_i,
    output logic [rx_pkg::SAMPLE_DW-1:0]          sample_o,
    output logic signed [IQ_W-1:0]                cos_o,
    output logic signed [IQ_W-1:0]                sin_o,
    output logic [rx_pkg::SAMPLE_ID_DW-1:0]       sample_id_o,
    output logic                                  valid_o
);

    logic [rx_pkg::LUT_BITS-1:0] lut_idx;

    // top phase bits pick the 45 degree sector
    assign lut_idx = phase_i[rx_pkg::PHASE_DW-1 -: rx_pkg::LUT_BITS];

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= valid_i;
        end
    end

    // vector, sample and index stay on the same pipeline slot
    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            cos_o       <= IQ_W'(rx_pkg::COS_TABLE[lut_idx]);
            sin_o       <= IQ_W'(rx_pkg::SIN_TABLE[lut_idx]);
            sample_o    <= sample_i;
            sample_id_o <= sample_id_i;
        end
    end

endmodule

`default_nettype wire

//--- source/cfo_tracker.sv
`timescale 1ns/1ps
`default_nettype none

module cfo_tracker (
    input  wire                                      clk_i,
    input  wire                                      reset_ni,
    input  wire        [rx_pkg::SAMPLE_DW-1:0]       sample_i,
    input  wire                                      sample_valid_i,
    input  wire signed [rx_pkg::PHASE_DW-1:0]        cfo_inc_i,
    input  wire                                      cfo_valid_i,
    input  wire rx_pkg::cfo_mode_e                   cfo_mode_i,
    output logic       [rx_pkg::SAMPLE_DW-1:0]       sample_o,
    output logic       [rx_pkg::PHASE_DW-1:0]        phase_o,
    output logic       [rx_pkg::SAMPLE_ID_DW-1:0]    sample_id_o,
    output logic                                     sample_valid_o
);

    logic signed [rx_pkg::PHASE_DW-1:0]     cfo_inc;
    logic        [rx_pkg::PHASE_DW-1:0]     phase;
    logic        [rx_pkg::SAMPLE_ID_DW-1:0] sample_cnt;

    // ------------------------------------------------------------------------
    // increment and phase
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            cfo_inc <= '0;
            phase   <= '0;
        end else if (cfo_mode_i == rx_pkg::CFO_MANUAL) begin
            cfo_inc <= '0;
            phase   <= '0;
        end else begin
            // reports are relative to the previous correction
            if (cfo_valid_i) begin
                cfo_inc <= cfo_inc - cfo_inc_i;
            end
            // step uses the increment from before this edge
            if (sample_valid_i) begin
                phase <= phase + $unsigned(cfo_inc);
            end
        end
    end

    // running sample index, counts in both modes
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            sample_cnt     <= '0;
            sample_valid_o <= 1'b0;
        end else begin
            sample_valid_o <= sample_valid_i;
            if (sample_valid_i) begin
                sample_cnt <= sample_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (sample_valid_i) begin
            sample_o    <= sample_i;
            phase_o     <= phase;
            sample_id_o <= sample_cnt;
        end
    end

    // manual mode leaves the next sample unrotated
    manual_clears_phase: assert property (
        @(posedge clk_i) disable iff (!reset_ni)
        (cfo_mode_i == rx_pkg::CFO_MANUAL) ##1 sample_valid_i |=> (phase_o == '0)
    );

endmodule

`default_nettype wire

//--- source/rx_pkg.sv
`default_nettype none

package rx_pkg;

    // ------------------------------------------------------------------------
    // widths
    // ------------------------------------------------------------------------
    localparam int IQ_DW        = 16;
    localparam int SAMPLE_DW    = 32;
    localparam int PHASE_DW     = 20;
    localparam int LUT_BITS     = 3;
    localparam int SAMPLE_ID_DW = 64;

    // rotator product scaling, table amplitude is 2^15 - 1
    localparam int FRAC_BITS    = 15;

    // ------------------------------------------------------------------------
    // tracker mode
    // ------------------------------------------------------------------------
    typedef enum logic {
        CFO_AUTO   = 1'b0,
        CFO_MANUAL = 1'b1
    } cfo_mode_e;

    // ------------------------------------------------------------------------
    // unit vector table, entry k at k * 45 degrees
    // ------------------------------------------------------------------------
    localparam logic signed [IQ_DW-1:0] COS_TABLE [0:7] = '{
        16'sd32767,
        16'sd23170,
        16'sd0,
        -16'sd23170,
        -16'sd32767,
        -16'sd23170,
        16'sd0,
        16'sd23170
    };

    localparam logic signed [IQ_DW-1:0] SIN_TABLE [0:7] = '{
        16'sd0,
        16'sd23170,
        16'sd32767,
        16'sd23170,
        16'sd0,
        -16'sd23170,
        -16'sd32767,
        -16'sd23170
    };

endpackage

`default_nettype wire
